// File: Makefile
# Verilator build for the CSI-2 packet builder testbench
# Any variable can be overridden, e.g. make sim TOP=csi2_tx_tb OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= csi2_tx_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing -Wno-fatal
LINT_FLAGS ?= -Wall --timing
PASS_TEXT  ?= TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+verilog
+incdir+tb
verilog/csi_pkg.sv
verilog/raw10_byte_packer.sv
verilog/csi_header_control.sv
verilog/csi_header_ecc.sv
verilog/csi_payload_crc.sv
verilog/csi_packet_serializer.sv
verilog/csi2_tx_top.sv
tb/csi2_tx_tb.sv

// File: tb/csi2_tx_model.svh
`ifndef CSI2_TX_MODEL_SVH
`define CSI2_TX_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, right shifting
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

// byte k of a RAW10 line: four MSB bytes, then the packed low bits
function automatic logic [7:0] raw10_byte(input logic [`CSI_IMAGE_X_SIZE*10-1:0] pix,
                                          input int k);
    int base;
    int slot;
    base = (k / 5) * 4;
    slot = k % 5;
    if (slot != 4) begin
        return pix[(base + slot) * 10 + 2 +: 8];
    end
    return {pix[(base + 3) * 10 +: 2], pix[(base + 2) * 10 +: 2],
            pix[(base + 1) * 10 +: 2], pix[base * 10 +: 2]};
endfunction

// header ECC from the syndrome table, one 6-bit column per data bit
function automatic logic [7:0] header_ecc(input csi_packet_hdr_t hdr);
    logic [143:0] columns;
    logic [23:0]  data;
    logic [5:0]   syndrome;
    // columns listed from D23 down to D0
    columns = {6'h3b, 6'h37, 6'h2f, 6'h1f, 6'h38, 6'h34, 6'h32, 6'h31,
               6'h2c, 6'h2a, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1c, 6'h1a,
               6'h19, 6'h16, 6'h15, 6'h13, 6'h0e, 6'h0d, 6'h0b, 6'h07};
    // data id goes out first, so it fills D7..D0
    data     = {hdr.wc, hdr.vc, hdr.dt};
    syndrome = '0;
    for (int i = 0; i < 24; i++) begin
        if (data[i]) begin
            syndrome ^= columns[i*6 +: 6];
        end
    end
    return {2'b00, syndrome};
endfunction

// CRC-16 x^16 + x^12 + x^5 + 1, bits taken lsb first
function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] value);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ value[i];
        // reflected taps sit on bits 15, 10 and 3
        c = {fb, c[15:1]} ^ {5'd0, fb, 6'd0, fb, 3'd0};
    end
    return c;
endfunction

function automatic logic [15:0] payload_crc(input logic [`CSI_IMAGE_X_SIZE*10-1:0] pix);
    logic [15:0] crc;
    crc = 16'hffff;
    for (int k = 0; k < `CSI_WORD_COUNT; k++) begin
        crc = crc16_update(crc, raw10_byte(pix, k));
    end
    return crc;
endfunction

`endif

// File: tb/csi2_tx_tb.sv
`timescale 1ns/1ns
`include "csi_params.svh"

module csi2_tx_tb import csi_pkg::*; ();

    localparam int WORD_COUNT = `CSI_WORD_COUNT;
    localparam int PIX_BITS   = `CSI_IMAGE_X_SIZE * 10;
    localparam int MAX_BYTES  = WORD_COUNT + 6;
    localparam int PACKETS    = 12;
    localparam int TIMEOUT    = 2000;

    logic        clock_camera_byte;
    logic        reset_camera_byte_n;
    pixel_beat_t pixel_i;
    csi_out_t    packet_o;

    logic [31:0]         lfsr_q;
    logic                stim_started;
    logic                in_packet;
    int                  rx_packets;
    int                  rx_count;
    logic [7:0]          rx_bytes [MAX_BYTES];
    csi_packet_hdr_t     exp_hdr_q [$];
    logic [PIX_BITS-1:0] exp_pix_q [$];

    `include "csi2_tx_model.svh"

    csi2_tx_top dut (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_i             (pixel_i),
        .packet_o            (packet_o)
    );

    always #50 clock_camera_byte = ~clock_camera_byte;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // one LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] expected,
                              input string what);
        if (got !== expected) begin
            abort_run($sformatf("error at %0t ns: %s byte is %02h, expected %02h",
                                $time, what, got, expected));
        end
    endtask

    task automatic check_header(input csi_packet_hdr_t got, input logic [7:0] got_ecc,
                                input csi_packet_hdr_t expected);
        if (got !== expected || got_ecc !== header_ecc(expected)) begin
            abort_run($sformatf("error at %0t ns: header vc %0d dt %02h wc %0d ecc %02h, %s",
                                $time, got.vc, got.dt, got.wc, got_ecc,
                                $sformatf("expected vc %0d dt %02h wc %0d ecc %02h",
                                          expected.vc, expected.dt, expected.wc,
                                          header_ecc(expected))));
        end
    endtask

    task automatic check_packet();
        csi_packet_hdr_t     got;
        csi_packet_hdr_t     expected;
        logic [PIX_BITS-1:0] pix;
        logic [15:0]         crc;
        if (exp_hdr_q.size() == 0) begin
            abort_run("a packet arrived that the stimulus never asked for");
        end
        expected = exp_hdr_q.pop_front();
        pix      = exp_pix_q.pop_front();
        if (rx_count != ((expected.wc == 16'd0) ? 4 : MAX_BYTES)) begin
            abort_run($sformatf("error at %0t ns: packet has %0d bytes", $time, rx_count));
        end
        got.vc = rx_bytes[0][7:6];
        got.dt = csi_data_type_e'(rx_bytes[0][5:0]);
        got.wc = {rx_bytes[2], rx_bytes[1]};
        check_header(got, rx_bytes[3], expected);
        if (expected.wc != 16'd0) begin
            for (int k = 0; k < WORD_COUNT; k++) begin
                check_byte(rx_bytes[4 + k], raw10_byte(pix, k), "payload");
            end
            crc = payload_crc(pix);
            check_byte(rx_bytes[WORD_COUNT + 4], crc[7:0], "crc low");
            check_byte(rx_bytes[WORD_COUNT + 5], crc[15:8], "crc high");
        end
        rx_packets++;
    endtask

    // collector samples away from the active edge
    always @(negedge clock_camera_byte) begin
        if (packet_o.valid) begin
            if (!stim_started) begin
                abort_run($sformatf("error at %0t ns: output valid before the first frame",
                                    $time));
            end
            if (packet_o.first) begin
                if (in_packet) begin
                    abort_run("a new packet started before the previous one ended");
                end
                in_packet = 1'b1;
                rx_count  = 0;
            end else if (!in_packet) begin
                abort_run("a byte arrived outside of any packet");
            end
            if (rx_count == MAX_BYTES) begin
                abort_run("a packet ran past the length of a line packet");
            end
            rx_bytes[rx_count] = packet_o.data;
            rx_count++;
            if (packet_o.last) begin
                in_packet = 1'b0;
                check_packet();
            end
        end
    end

    task automatic send_line(input logic [PIX_BITS-1:0] pix);
        @(posedge clock_camera_byte);
        pixel_i.line_valid <= 1'b1;
        for (int i = 0; i < `CSI_IMAGE_X_SIZE; i++) begin
            repeat (random_bits(2)) @(posedge clock_camera_byte);
            @(posedge clock_camera_byte);
            pixel_i.pixel_valid <= 1'b1;
            pixel_i.data        <= pix[i*10 +: 10];
            // strobe never held for two cycles
            @(posedge clock_camera_byte);
            pixel_i.pixel_valid <= 1'b0;
        end
        pixel_i.line_valid <= 1'b0;
    endtask

    task automatic send_frame();
        logic [PIX_BITS-1:0] pix;
        csi_packet_hdr_t     hdr;
        hdr.vc = 2'd0;
        hdr.dt = frame_start;
        hdr.wc = 16'd0;
        exp_hdr_q.push_back(hdr);
        exp_pix_q.push_back('0);
        @(posedge clock_camera_byte);
        pixel_i.frame_valid <= 1'b1;
        stim_started = 1'b1;
        for (int row = 0; row < 4; row++) begin
            repeat (1 + random_bits(3)) @(posedge clock_camera_byte);
            for (int i = 0; i < `CSI_IMAGE_X_SIZE; i++) begin
                pix[i*10 +: 10] = 10'(random_bits(10));
            end
            hdr.dt = raw10;
            hdr.wc = 16'(WORD_COUNT);
            exp_hdr_q.push_back(hdr);
            exp_pix_q.push_back(pix);
            send_line(pix);
        end
        repeat (1 + random_bits(2)) @(posedge clock_camera_byte);
        pixel_i.frame_valid <= 1'b0;
        hdr.dt = frame_end;
        hdr.wc = 16'd0;
        exp_hdr_q.push_back(hdr);
        exp_pix_q.push_back('0);
    endtask

    initial begin
        int waited;
        clock_camera_byte   = 1'b0;
        reset_camera_byte_n = 1'b0;
        pixel_i             = '0;
        lfsr_q              = 32'hbd6f;
        stim_started        = 1'b0;
        in_packet           = 1'b0;
        rx_packets          = 0;
        rx_count            = 0;
        repeat (4) @(posedge clock_camera_byte);
        reset_camera_byte_n <= 1'b1;
        repeat (2 + random_bits(3)) @(posedge clock_camera_byte);
        for (int frame = 0; frame < 2; frame++) begin
            send_frame();
            repeat (2 + random_bits(3)) @(posedge clock_camera_byte);
        end
        waited = 0;
        while (rx_packets < PACKETS && waited < TIMEOUT) begin
            @(posedge clock_camera_byte);
            waited++;
        end
        if (rx_packets < PACKETS) begin
            abort_run("timeout while waiting for the DUT to send all packets");
        end
        // a stray packet would show up in this quiet tail
        repeat (20) @(posedge clock_camera_byte);
        if (in_packet) begin
            abort_run("a packet was still open when the run ended");
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: verilog/csi2_tx_top.sv
`timescale 1ns/1ns

module csi2_tx_top import csi_pkg::*; (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  pixel_beat_t pixel_i,
    output csi_out_t    packet_o
);

    logic            frame_start_pulse;
    logic            frame_end_pulse;
    logic            line_start_pulse;
    byte_beat_t      packed_byte;
    csi_packet_hdr_t hdr;
    logic            hdr_valid;
    logic            busy;

    raw10_byte_packer u_packer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_i             (pixel_i),
        .frame_start_o       (frame_start_pulse),
        .frame_end_o         (frame_end_pulse),
        .line_start_o        (line_start_pulse),
        .byte_o              (packed_byte)
    );

    // packet type and word count selection
    csi_header_control u_header_control (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .frame_start_i       (frame_start_pulse),
        .frame_end_i         (frame_end_pulse),
        .line_start_i        (line_start_pulse),
        .busy_i              (busy),
        .hdr_o               (hdr),
        .hdr_valid_o         (hdr_valid)
    );

    csi_packet_serializer u_serializer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .hdr_i               (hdr),
        .hdr_valid_i         (hdr_valid),
        .byte_i              (packed_byte),
        .busy_o              (busy),
        .packet_o            (packet_o)
    );

endmodule

// File: verilog/csi_header_control.sv
`timescale 1ns/1ns
`include "csi_params.svh"

module csi_header_control import csi_pkg::*; (
    input  logic            clock_camera_byte,
    input  logic            reset_camera_byte_n,
    input  logic            frame_start_i,
    input  logic            frame_end_i,
    input  logic            line_start_i,
    input  logic            busy_i,
    output csi_packet_hdr_t hdr_o,
    output logic            hdr_valid_o
);

    logic fs_pend_q;
    logic ls_pend_q;
    logic fe_pend_q;
    logic fs_req;
    logic ls_req;
    logic fe_req;
    logic can_issue;
    logic pick_fs;
    logic pick_ls;
    logic pick_fe;

    assign fs_req = fs_pend_q | frame_start_i;
    assign ls_req = ls_pend_q | line_start_i;
    assign fe_req = fe_pend_q | frame_end_i;

    // busy only rises after the strobe, so skip the strobe cycle itself
    assign can_issue = ~busy_i & ~hdr_valid_o;

    // oldest first: a pending frame end precedes the next frame start,
    // otherwise frame start, then lines, then frame end
    assign pick_fe = can_issue & fe_req & (fs_req | ~ls_req);
    assign pick_fs = can_issue & fs_req & ~fe_req;
    assign pick_ls = can_issue & ls_req & ~fs_req;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            fs_pend_q   <= 1'b0;
            ls_pend_q   <= 1'b0;
            fe_pend_q   <= 1'b0;
            hdr_valid_o <= 1'b0;
        end else begin
            fs_pend_q   <= fs_req & ~pick_fs;
            ls_pend_q   <= ls_req & ~pick_ls;
            fe_pend_q   <= fe_req & ~pick_fe;
            hdr_valid_o <= pick_fs | pick_ls | pick_fe;
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        hdr_o.vc <= 2'd0;
        if (pick_fe) begin
            hdr_o.dt <= frame_end;
            hdr_o.wc <= 16'd0;
        end else if (pick_fs) begin
            hdr_o.dt <= frame_start;
            hdr_o.wc <= 16'd0;
        end else if (pick_ls) begin
            hdr_o.dt <= raw10;
            hdr_o.wc <= 16'(`CSI_WORD_COUNT);
        end
    end

endmodule

// File: verilog/csi_header_ecc.sv
`timescale 1ns/1ns

module csi_header_ecc import csi_pkg::*; (
    input  csi_packet_hdr_t hdr_i,
    output logic [7:0]      ecc_o
);

    logic [23:0] d;
    logic [5:0]  p;

    // wire order: data identifier in bits 7:0, word count above it
    assign d = {hdr_i.wc, hdr_i.vc, hdr_i.dt};

    assign p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^
                  d[13] ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];

    assign p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^
                  d[14] ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];

    assign p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^
                  d[15] ^ d[18] ^ d[20] ^ d[21] ^ d[22];

    assign p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^
                  d[15] ^ d[19] ^ d[20] ^ d[21] ^ d[23];

    assign p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^
                  d[18] ^ d[19] ^ d[20] ^ d[22] ^ d[23];

    assign p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^
                  d[17] ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];

    // the two spare bits stay zero
    assign ecc_o = {2'b00, p};

endmodule

// File: verilog/csi_packet_serializer.sv
`timescale 1ns/1ns
`include "csi_params.svh"

module csi_packet_serializer import csi_pkg::*; (
    input  logic            clock_camera_byte,
    input  logic            reset_camera_byte_n,
    input  csi_packet_hdr_t hdr_i,
    input  logic            hdr_valid_i,
    input  byte_beat_t      byte_i,
    output logic            busy_o,
    output csi_out_t        packet_o
);

    localparam int FIFO_DEPTH = `CSI_BYTE_FIFO_DEPTH;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    logic [7:0]         fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   fifo_count_q;
    logic               fifo_empty;
    logic               push;
    logic               pop;

    serializer_state_e  state_q;
    csi_packet_hdr_t    hdr_q;
    logic [1:0]         index_q;
    logic [15:0]        remaining_q;
    logic               short_packet;
    logic [7:0]         ecc;
    logic [7:0]         header_byte;
    logic [15:0]        crc_value;

    // payload buffer, written in every state
    assign push       = byte_i.valid;
    assign fifo_empty = (fifo_count_q == '0);
    assign pop        = (state_q == payload) & ~fifo_empty;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            fifo_count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            fifo_count_q <= fifo_count_q + (FIFO_AW + 1)'(push) - (FIFO_AW + 1)'(pop);
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= byte_i.data;
        end
        if (hdr_valid_i && (state_q == idle)) begin
            hdr_q <= hdr_i;
        end
    end

    assign short_packet = (hdr_q.wc == 16'd0);
    assign busy_o       = (state_q != idle);

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state_q     <= idle;
            index_q     <= 2'd0;
            remaining_q <= 16'd0;
        end else begin
            case (state_q)
                idle: begin
                    if (hdr_valid_i) begin
                        state_q <= header;
                        index_q <= 2'd0;
                    end
                end
                header: begin
                    index_q <= index_q + 2'd1;
                    if (index_q == 2'd3) begin
                        state_q     <= short_packet ? idle : payload;
                        remaining_q <= hdr_q.wc;
                    end
                end
                payload: begin
                    // payload rate follows the packer, one byte per pop
                    if (pop) begin
                        remaining_q <= remaining_q - 16'd1;
                        if (remaining_q == 16'd1) begin
                            state_q <= crc;
                            index_q <= 2'd0;
                        end
                    end
                end
                default: begin
                    index_q <= index_q + 2'd1;
                    if (index_q == 2'd1) begin
                        state_q <= idle;
                    end
                end
            endcase
        end
    end

    csi_header_ecc u_header_ecc (
        .hdr_i (hdr_q),
        .ecc_o (ecc)
    );

    csi_payload_crc u_payload_crc (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .clear_i             (hdr_valid_i),
        .byte_valid_i        (pop),
        .byte_i              (fifo_mem[rd_ptr_q]),
        .crc_o               (crc_value)
    );

    // header byte order: data id, wc low, wc high, ecc
    always_comb begin
        case (index_q)
            2'd0: header_byte = {hdr_q.vc, hdr_q.dt};
            2'd1: header_byte = hdr_q.wc[7:0];
            2'd2: header_byte = hdr_q.wc[15:8];
            default: header_byte = ecc;
        endcase
    end

    always_comb begin
        packet_o = '0;
        case (state_q)
            header: begin
                packet_o.valid = 1'b1;
                packet_o.first = (index_q == 2'd0);
                packet_o.last  = (index_q == 2'd3) & short_packet;
                packet_o.data  = header_byte;
            end
            payload: begin
                packet_o.valid = ~fifo_empty;
                packet_o.data  = fifo_mem[rd_ptr_q];
            end
            crc: begin
                // checksum low byte goes out first
                packet_o.valid = 1'b1;
                packet_o.last  = (index_q == 2'd1);
                packet_o.data  = (index_q == 2'd0) ? crc_value[7:0] : crc_value[15:8];
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/csi_params.svh
`ifndef CSI_PARAMS_SVH
`define CSI_PARAMS_SVH

// active pixels per line, must be a multiple of four
`define CSI_IMAGE_X_SIZE 8

// RAW10 payload bytes per line: four pixels pack into five bytes
`define CSI_WORD_COUNT ((`CSI_IMAGE_X_SIZE) * 5 / 4)

// payload byte buffer in front of the packet serializer
`define CSI_BYTE_FIFO_DEPTH 16

`endif

// File: verilog/csi_payload_crc.sv
`timescale 1ns/1ns

module csi_payload_crc (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        clear_i,
    input  logic        byte_valid_i,
    input  logic [7:0]  byte_i,
    output logic [15:0] crc_o
);

    // one byte through the reflected polynomial, lsb first
    function automatic logic [15:0] crc_next(input logic [15:0] crc_in,
                                             input logic [7:0] data);
        logic [15:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ 16'h8408;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            crc_o <= 16'hffff;
        end else if (clear_i) begin
            crc_o <= 16'hffff;
        end else if (byte_valid_i) begin
            crc_o <= crc_next(crc_o, byte_i);
        end
    end

endmodule

// File: verilog/csi_pkg.sv
package csi_pkg;

    // CSI-2 data identifiers used by this transmitter
    typedef enum logic [5:0] {
        frame_start = 6'h00,
        frame_end   = 6'h01,
        raw10       = 6'h2b
    } csi_data_type_e;

    // 24 header bits ahead of the ECC byte
    typedef struct packed {
        logic [1:0]     vc;
        csi_data_type_e dt;
        logic [15:0]    wc;
    } csi_packet_hdr_t;

    // camera timing levels plus pixel strobe
    typedef struct packed {
        logic       frame_valid;
        logic       line_valid;
        logic       pixel_valid;
        logic [9:0] data;
    } pixel_beat_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // outgoing packet byte stream
    typedef struct packed {
        logic       valid;
        logic       first;
        logic       last;
        logic [7:0] data;
    } csi_out_t;

    typedef enum logic [1:0] {
        idle,
        header,
        payload,
        crc
    } serializer_state_e;

endpackage

// File: verilog/raw10_byte_packer.sv
`timescale 1ns/1ns

module raw10_byte_packer import csi_pkg::*; (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  pixel_beat_t pixel_i,
    output logic        frame_start_o,
    output logic        frame_end_o,
    output logic        line_start_o,
    output byte_beat_t  byte_o
);

    logic       frame_valid_q;
    logic       line_valid_q;
    logic [1:0] pixel_count_q;
    logic       lsb_pending_q;
    logic       byte_valid_q;
    logic [7:0] byte_data_q;
    logic [7:0] lsb_acc_q;
    logic       pixel_strobe;

    // a pixel only counts inside an active line of an active frame
    assign pixel_strobe = pixel_i.pixel_valid & pixel_i.line_valid & pixel_i.frame_valid;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            line_start_o  <= 1'b0;
            pixel_count_q <= 2'd0;
            lsb_pending_q <= 1'b0;
            byte_valid_q  <= 1'b0;
        end else begin
            frame_valid_q <= pixel_i.frame_valid;
            line_valid_q  <= pixel_i.line_valid;

            // edge events, one cycle after the level change
            frame_start_o <= pixel_i.frame_valid & ~frame_valid_q;
            frame_end_o   <= ~pixel_i.frame_valid & frame_valid_q;
            line_start_o  <= pixel_i.line_valid & ~line_valid_q;

            // group position restarts with every line
            if (!pixel_i.line_valid) begin
                pixel_count_q <= 2'd0;
            end else if (pixel_strobe) begin
                pixel_count_q <= pixel_count_q + 2'd1;
            end

            lsb_pending_q <= pixel_strobe && (pixel_count_q == 2'd3);
            byte_valid_q  <= pixel_strobe | lsb_pending_q;
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (pixel_strobe) begin
            // low bits gathered per group, pixel 0 in the lowest slot
            case (pixel_count_q)
                2'd0: lsb_acc_q[1:0] <= pixel_i.data[1:0];
                2'd1: lsb_acc_q[3:2] <= pixel_i.data[1:0];
                2'd2: lsb_acc_q[5:4] <= pixel_i.data[1:0];
                default: lsb_acc_q[7:6] <= pixel_i.data[1:0];
            endcase
        end

        // the pixel rule leaves the cycle after pixel 3 free for the LSB byte
        if (lsb_pending_q) begin
            byte_data_q <= lsb_acc_q;
        end else begin
            byte_data_q <= pixel_i.data[9:2];
        end
    end

    assign byte_o.valid = byte_valid_q;
    assign byte_o.data  = byte_data_q;

endmodule
